//--- common/fetch_pkg.sv
// structs carried between memory, fetch stage, fetch queue and retire; import in fetch blocks
package fetch_pkg;

  ////////////////////////////////////////////////////////////
  // fetch to dispatch
  ////////////////////////////////////////////////////////////

  // one fetched instruction on its way to dispatch
  typedef struct packed {
    isa_pkg::pc_t          pc;        // address of inst
    isa_pkg::pc_t          npc;       // pc + 4, no prediction
    isa_pkg::inst_t        inst;
    isa_pkg::opcode_class_e op_class; // predecode result
  } fetch_packet_t;

  ////////////////////////////////////////////////////////////
  // retire to fetch
  ////////////////////////////////////////////////////////////

  // committed branch outcome, taken only when all three flags are set
  typedef struct packed {
    logic         valid_inst;    // retire slot holds a real instruction
    logic         branch_valid;  // that instruction is a branch
    logic         take_branch;   // resolved taken
    isa_pkg::pc_t target_pc;     // where fetch restarts
  } redirect_t;

  ////////////////////////////////////////////////////////////
  // program load port
  ////////////////////////////////////////////////////////////

  typedef logic [15:0] line_idx_t;   // wide enough for any sane memory depth

  typedef struct packed {
    logic           en;     // write strobe
    line_idx_t      addr;   // line index, not a byte address
    isa_pkg::line_t data;   // two instructions
  } imem_write_t;

endpackage

//--- common/isa_pkg.sv
// instruction set definitions shared by the fetch front end; import where widths or opcodes are needed
package isa_pkg;

  ////////////////////////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////////////////////////

  localparam int xlen = 64;                     // program counter width
  localparam int ilen = 32;                     // one uncompressed instruction
  localparam int line_bits = 2 * ilen;          // memory line holds two instructions

  typedef logic [xlen-1:0]      pc_t;
  typedef logic [ilen-1:0]      inst_t;
  typedef logic [line_bits-1:0] line_t;         // lower half is the even word

  localparam pc_t inst_bytes = 64'd4;           // sequential step, no compressed forms

  ////////////////////////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////////////////////////

  // major opcode sits in the low seven bits
  localparam int opcode_lsb = 0;
  localparam int opcode_msb = 6;

  typedef logic [opcode_msb:opcode_lsb] opcode_t;

  localparam opcode_t op_branch = 7'b1100011;   // beq/bne/blt/bge/bltu/bgeu
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_jalr   = 7'b1100111;

  // control flow class attached to each fetched instruction
  typedef enum logic [1:0] {
    class_branch = 2'd0,
    class_jal    = 2'd1,
    class_jalr   = 2'd2,
    class_other  = 2'd3
  } opcode_class_e;

endpackage

//--- design/fetch_unit.sv
// fetch front end top level; ties instruction memory, fetch stage and fetch queue together
`timescale 1ns/1ns

module fetch_unit #(
  parameter int imem_lines  = 256,   // instruction memory depth in lines
  parameter int queue_depth = 4      // fetch queue entries, power of two
) (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::imem_write_t   imem_write,   // program load
  input  fetch_pkg::redirect_t     redirect,     // from retire
  input  logic                     dispatch_en,
  output logic                     out_valid,
  output fetch_pkg::fetch_packet_t out_packet
);

  import isa_pkg::*;
  import fetch_pkg::*;

  ////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////

  pc_t           imem_addr;
  line_t         imem_data;
  logic          imem_valid;
  logic          push;
  logic          flush;
  logic          full;
  fetch_packet_t packet;            // fetch stage to queue

  imem #(
    .imem_lines (imem_lines)
  ) i_imem (
    .clock (clock),
    .reset (reset),
    .write (imem_write),
    .addr  (imem_addr),
    .data  (imem_data),
    .valid (imem_valid)
  );

  fetch_stage #(
    .imem_lines (imem_lines)
  ) i_fetch_stage (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .imem_data  (imem_data),
    .imem_valid (imem_valid),
    .full       (full),
    .imem_addr  (imem_addr),
    .push       (push),
    .packet     (packet),
    .flush      (flush)
  );

  fetch_queue #(
    .queue_depth (queue_depth)
  ) i_fetch_queue (
    .clock       (clock),
    .reset       (reset),
    .push        (push),
    .packet      (packet),
    .flush       (flush),
    .dispatch_en (dispatch_en),
    .full        (full),
    .out_valid   (out_valid),
    .out_packet  (out_packet)
  );

endmodule

//--- design/imem.sv
// single-cycle instruction memory with combinational line read and synchronous program load
`timescale 1ns/1ns

module imem #(
  parameter int imem_lines = 256          // depth in lines, power of two
) (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::imem_write_t write,   // load port from the testbench
  input  isa_pkg::pc_t           addr,    // byte address, line aligned by fetch
  output isa_pkg::line_t         data,
  output logic                   valid
);

  import isa_pkg::*;

  localparam int idx_w = $clog2(imem_lines);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  line_t            mem [imem_lines];    // program image, loaded after reset
  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] wr_idx;
  logic             mem_ready;           // low through reset and one cycle past it

  // line bits of the byte address, upper bits dropped so reads wrap
  assign rd_idx = addr[idx_w+2:3];
  assign wr_idx = write.addr[idx_w-1:0];  // load index wraps the same way

  // load write lands at the edge
  always_ff @(posedge clock) begin
    if (write.en) begin
      mem[wr_idx] <= write.data;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  assign data = mem[rd_idx];    // combinational read

  // ready flag drops with reset and comes back on the first free edge
  always_ff @(posedge clock) begin
    if (reset) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= 1'b1;
    end
  end

  // a read racing a load write is not trusted
  assign valid = mem_ready & ~write.en;

endmodule

//--- dv/fetch_unit_properties.sv
// queue checks bound into fetch_queue; depth bound, no push while full, empty after reset or flush
`timescale 1ns/1ns

module fetch_unit_properties #(
  parameter int queue_depth = 4            // must match the bound queue
) (
  input logic                         clock,
  input logic                         reset,
  input logic                         push,
  input logic                         flush,
  input logic                         full,
  input logic                         out_valid,
  input logic [$clog2(queue_depth):0] count
);

  localparam int ptr_w = $clog2(queue_depth);

  int failures = 0;   // tally of failed properties

  ////////////////////////////////////////////////////////////
  // occupancy
  ////////////////////////////////////////////////////////////

  // count never runs past the depth
  count_in_range: assert property (@(posedge clock) disable iff (reset)
    count <= (ptr_w + 1)'(queue_depth))
    else begin
      $error("queue count %0d above depth %0d", count, queue_depth);
      failures++;
    end

  // fetch stage must hold off while the queue is full
  no_push_when_full: assert property (@(posedge clock) disable iff (reset)
    !(push && full))
    else begin
      $error("push while the fetch queue is full");
      failures++;
    end

  ////////////////////////////////////////////////////////////
  // reset and flush
  ////////////////////////////////////////////////////////////

  empty_after_reset: assert property (@(posedge clock) reset |=> !out_valid)
    else begin
      $error("out_valid high on the cycle after reset");
      failures++;
    end

  empty_after_flush: assert property (@(posedge clock) disable iff (reset)
    flush |=> !out_valid)
    else begin
      $error("out_valid high on the cycle after a flush");
      failures++;
    end

endmodule

bind fetch_queue fetch_unit_properties #(
  .queue_depth (queue_depth)
) i_fetch_unit_properties (
  .clock     (clock),
  .reset     (reset),
  .push      (push),
  .flush     (flush),
  .full      (full),
  .out_valid (out_valid),
  .count     (count)
);

//--- dv/fetch_unit_tb.sv
// testbench for the fetch front end; loads a random program, drives dispatch and retire, checks the stream
`timescale 1ns/1ns

module fetch_unit_tb;

  import isa_pkg::*;
  import fetch_pkg::*;

  localparam int imem_lines  = 256;
  localparam int queue_depth = 4;
  localparam int idx_w       = $clog2(imem_lines);

  logic          clock;
  logic          reset;
  imem_write_t   imem_write;
  redirect_t     redirect;
  logic          dispatch_en;
  logic          out_valid;
  fetch_packet_t out_packet;

  line_t image [imem_lines];   // copy of the loaded program
  pc_t   exp_pc;               // pc of the next packet dispatch should see
  int    accepted;             // packets taken by dispatch so far
  string test_name;

  fetch_unit #(
    .imem_lines  (imem_lines),
    .queue_depth (queue_depth)
  ) i_fetch_unit (
    .clock       (clock),
    .reset       (reset),
    .imem_write  (imem_write),
    .redirect    (redirect),
    .dispatch_en (dispatch_en),
    .out_valid   (out_valid),
    .out_packet  (out_packet)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;   // 4 ns period
  end

  ////////////////////////////////////////////////////////////
  // reporting and reference helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "fetch_unit_tb stopped on first error");
  endtask

  task automatic report_mismatch(input string field, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_run($sformatf("MISMATCH test=%s field=%s expected=%h actual=%h",
                       test_name, field, expected, actual));
  endtask

  // major opcode to control flow class
  function automatic opcode_class_e classify(input inst_t word);
    case (word[6:0])
      7'b1100011: return class_branch;
      7'b1101111: return class_jal;
      7'b1100111: return class_jalr;
      default:    return class_other;
    endcase
  endfunction

  // word aligned target somewhere inside the program
  function automatic pc_t random_target();
    return pc_t'($urandom_range(2 * imem_lines - 1, 0)) << 2;
  endfunction

  task automatic check_packet(input fetch_packet_t pkt);
    line_t line;
    inst_t exp_inst;
    line     = image[exp_pc[idx_w+2:3]];                  // wraps like the memory
    exp_inst = exp_pc[2] ? line[63:32] : line[31:0];      // odd word is the upper half
    assert (pkt.pc == exp_pc) else report_mismatch("pc", exp_pc, pkt.pc);
    assert (pkt.npc == exp_pc + 64'd4) else report_mismatch("npc", exp_pc + 64'd4, pkt.npc);
    assert (pkt.inst == exp_inst) else report_mismatch("inst", 64'(exp_inst), 64'(pkt.inst));
    assert (pkt.op_class == classify(exp_inst))
      else report_mismatch("op_class", 64'(classify(exp_inst)), 64'(pkt.op_class));
  endtask

  ////////////////////////////////////////////////////////////
  // scoreboard, sampled on the edge where the handshake happens
  ////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      exp_pc   = '0;                       // fetch boots from 0
      accepted <= 0;
    end else begin
      if (out_valid && dispatch_en) begin
        check_packet(out_packet);
        exp_pc = exp_pc + 64'd4;           // no prediction, always fall through
        accepted <= accepted + 1;
      end
      // taken only with all three retire flags
      if (redirect.valid_inst && redirect.branch_valid && redirect.take_branch) begin
        exp_pc = redirect.target_pc;
      end
    end
  end

  always @(posedge clock) begin
    if (i_fetch_unit.i_fetch_queue.i_fetch_unit_properties.failures != 0) begin
      stop_run("a queue assertion bound into the fetch queue failed");
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic load_program();
    inst_t lo;
    inst_t hi;
    for (int i = 0; i < imem_lines; i++) begin
      lo = $urandom;
      hi = $urandom;
      case (i % 4)                         // sprinkle control flow opcodes
        1: lo[6:0] = 7'b1100011;
        2: hi[6:0] = 7'b1101111;
        3: lo[6:0] = 7'b1100111;
        default: ;
      endcase
      image[i] = {hi, lo};
      @(posedge clock);
      // memory is busy loading, nothing may reach the queue yet
      assert (!out_valid) else stop_run("out_valid went high while the program was loading");
      imem_write <= '{en: 1'b1, addr: line_idx_t'(i), data: {hi, lo}};
    end
    @(posedge clock);
    assert (!out_valid) else stop_run("out_valid went high while the program was loading");
    imem_write <= '0;
  endtask

  task automatic wait_accepted(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (accepted < target && cycles <= limit) begin
      @(posedge clock);
      cycles++;
    end
    if (accepted < target) begin
      stop_run($sformatf("timeout in test %s: %0d of %0d packets accepted after %0d cycles",
                         test_name, accepted, target, limit));
    end
  endtask

  task automatic send_redirect(input logic [2:0] flags, input pc_t target);
    @(posedge clock);
    redirect <= '{valid_inst: flags[2], branch_valid: flags[1], take_branch: flags[0],
                  target_pc: target};
    @(posedge clock);
    redirect <= '0;                        // one cycle pulse from retire
  endtask

  task automatic random_stalls(input int cycles);
    int stall_left;
    stall_left = 0;
    repeat (cycles) begin
      @(posedge clock);
      if (stall_left > 0) begin
        dispatch_en <= 1'b0;
        stall_left--;
      end else if ($urandom_range(7, 0) == 0) begin
        stall_left = $urandom_range(16, 6);   // long enough to fill the queue
        dispatch_en <= 1'b0;
      end else begin
        dispatch_en <= ($urandom_range(1, 0) == 1);
      end
    end
    @(posedge clock);
    dispatch_en <= 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [2:0] flags;
    reset       = 1'b1;
    imem_write  = '0;
    redirect    = '0;
    dispatch_en = 1'b0;
    test_name   = "reset";
    void'($urandom(75991));
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    test_name = "load";
    load_program();
    test_name = "sequential";
    @(posedge clock);
    dispatch_en <= 1'b1;
    wait_accepted(40, 200);
    test_name = "stall";
    random_stalls(300);
    wait_accepted(accepted + 10, 200);
    test_name = "redirect";
    repeat (6) begin
      send_redirect(3'b111, random_target());
      wait_accepted(accepted + 12, 200);
    end
    // redirect while the queue sits full
    @(posedge clock);
    dispatch_en <= 1'b0;
    repeat (8) @(posedge clock);
    send_redirect(3'b111, random_target());
    @(posedge clock);
    dispatch_en <= 1'b1;
    wait_accepted(accepted + 8, 200);
    test_name = "redirect_not_taken";
    for (int i = 0; i < 6; i++) begin
      flags = 3'b111 ^ (3'b001 << (i % 3));   // each flag dropped in turn
      send_redirect(flags, random_target());
      wait_accepted(accepted + 6, 200);
    end
    repeat (4) @(posedge clock);
    if (i_fetch_unit.i_fetch_queue.i_fetch_unit_properties.failures == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_run("queue assertions reported failures during the run");
    end
  end

endmodule

//--- fetch/fetch_queue.sv
// circular fetch queue between fetch and dispatch; flushed on a taken redirect
`timescale 1ns/1ns

module fetch_queue #(
  parameter int queue_depth = 4            // entries, power of two
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     push,
  input  fetch_pkg::fetch_packet_t packet,
  input  logic                     flush,
  input  logic                     dispatch_en,
  output logic                     full,
  output logic                     out_valid,
  output fetch_pkg::fetch_packet_t out_packet
);

  import fetch_pkg::*;

  localparam int ptr_w = $clog2(queue_depth);

  ////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////

  fetch_packet_t    entries [queue_depth];   // payload only, no reset
  logic [ptr_w-1:0] head_ptr;                // oldest entry
  logic [ptr_w-1:0] tail_ptr;                // next free slot
  logic [ptr_w:0]   count;                   // one extra bit to tell full from empty
  logic             do_push;
  logic             do_pop;

  assign full      = count == (ptr_w + 1)'(queue_depth);
  assign out_valid = count != '0;
  assign out_packet = entries[head_ptr];     // head is visible while valid

  // full already blocks push upstream, guard here as well
  assign do_push = push & ~full;
  assign do_pop  = out_valid & dispatch_en;

  always_ff @(posedge clock) begin
    if (do_push) begin
      entries[tail_ptr] <= packet;
    end
  end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head_ptr <= '0;                        // realign to slot 0
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (do_push) begin
        tail_ptr <= tail_ptr + 1'b1;         // wraps at depth
      end
      if (do_pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;             // both or neither
      endcase
    end
  end

endmodule

//--- fetch/fetch_stage.sv
// fetch stage: holds the pc, picks the next pc, selects the half line and predecodes it
`timescale 1ns/1ns

module fetch_stage #(
  parameter int imem_lines = 256           // memory depth, used for address wrap
) (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::redirect_t     redirect,   // from retire
  input  isa_pkg::line_t           imem_data,
  input  logic                     imem_valid,
  input  logic                     full,       // queue back pressure
  output isa_pkg::pc_t             imem_addr,
  output logic                     push,
  output fetch_pkg::fetch_packet_t packet,
  output logic                     flush       // empties the queue
);

  import isa_pkg::*;

  localparam int idx_w = $clog2(imem_lines);

  ////////////////////////////////////////////////////////////
  // pc register
  ////////////////////////////////////////////////////////////

  pc_t           pc;               // pc being fetched this cycle
  pc_t           pc_plus_4;
  pc_t           next_pc;
  logic          redirect_taken;
  inst_t         inst;
  opcode_class_e op_class;

  assign pc_plus_4 = pc + inst_bytes;

  // all three retire flags must agree before fetch moves
  assign redirect_taken = redirect.valid_inst & redirect.branch_valid & redirect.take_branch;

  assign flush = redirect_taken;

  // redirect wins over stall, so a taken branch is never lost
  assign push = imem_valid & ~full & ~redirect_taken;

  always_comb begin
    next_pc = pc;                             // hold on stall
    if (redirect_taken) begin
      next_pc = redirect.target_pc;
    end else if (push) begin
      next_pc = pc_plus_4;                    // no prediction, just fall through
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;                               // boot from address 0
    end else begin
      pc <= next_pc;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory address and half select
  ////////////////////////////////////////////////////////////

  // line aligned and wrapped to the memory depth
  assign imem_addr = pc_t'({pc[idx_w+2:3], 3'b000});

  // memory returns two words, bit 2 picks the one we want
  assign inst = pc[2] ? imem_data[2*ilen-1:ilen] : imem_data[ilen-1:0];

  ////////////////////////////////////////////////////////////
  // predecode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (inst[opcode_msb:opcode_lsb])
      op_branch: op_class = class_branch;     // conditional
      op_jal:    op_class = class_jal;        // direct jump
      op_jalr:   op_class = class_jalr;       // indirect jump
      default:   op_class = class_other;
    endcase
  end

  // packet goes to the queue, push says whether it counts
  assign packet.pc       = pc;
  assign packet.npc      = pc_plus_4;
  assign packet.inst     = inst;
  assign packet.op_class = op_class;

endmodule

//--- run.sh
#!/bin/sh
# build the fetch unit testbench with Verilator, run it, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f src.f --top-module fetch_unit_tb -o fetch_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_unit_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" "$log"; then
  echo "simulation run ok"
  exit 0
fi
echo "pass message not found in $log"
exit 1

//--- src.f
common/isa_pkg.sv
common/fetch_pkg.sv
design/imem.sv
fetch/fetch_stage.sv
fetch/fetch_queue.sv
design/fetch_unit.sv
dv/fetch_unit_properties.sv
dv/fetch_unit_tb.sv
